/* logic/posit_format_pkg.sv */
// Fixed to 32-bit posits with es = 3; every derived width below follows from those two
// Scale is two's complement regime*2^es + exponent

`default_nettype none

package posit_format_pkg;

    localparam int POSIT_WIDTH = 32;
    localparam int POSIT_ES = 3;

    // Regime k spans -30..30, so 6 bits of k plus es exponent bits
    localparam int SCALE_WIDTH = $clog2(POSIT_WIDTH) + 1 + POSIT_ES;

    // Sign, shortest regime (2 bits) and exponent leave this many fraction bits
    localparam int FRAC_WIDTH = POSIT_WIDTH - 3 - POSIT_ES;

    // Sum fraction carries 4 guard bits below the stored fraction
    localparam int SUM_FRAC_WIDTH = FRAC_WIDTH + 4;

    // Not-a-real, sign bit alone
    localparam logic [POSIT_WIDTH-1:0] NAR_PATTERN = {1'b1, {(POSIT_WIDTH-1){1'b0}}};

endpackage

`default_nettype wire

/* logic/posit_raw_pkg.sv */
// Raw (decoded) posit values passed between decoder, adder and encoder
// Scale fields hold two's complement numbers; apply $signed() before comparing them

`default_nettype none

package posit_raw_pkg;

    // Decoded operand, fraction excludes the hidden bit
    typedef struct packed {
        logic                                     sign;
        logic [posit_format_pkg::SCALE_WIDTH-1:0] scale;
        logic [posit_format_pkg::FRAC_WIDTH-1:0]  fraction;
        logic                                     inf;  // NaR operand
        logic                                     zero; // Other fields cleared when set
    } raw_value_t;

    // Normalized adder result with guard bits for the encoder
    typedef struct packed {
        logic                                        sign;
        logic [posit_format_pkg::SCALE_WIDTH-1:0]    scale;
        logic [posit_format_pkg::SUM_FRAC_WIDTH-1:0] fraction;
        logic                                        inf;
        logic                                        zero;
    } raw_sum_t;

    // Both decoded operands of one addition
    typedef struct packed {
        raw_value_t a;
        raw_value_t b;
    } raw_pair_t;

endpackage

`default_nettype wire

/* logic/posit_decode.sv */
// Decodes both posit operands into raw form, one register stage
// Zero and NaR words are flagged and leave the other raw fields cleared

`timescale 1ns/1ps
`default_nettype none

module posit_decode (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    input  wire logic [posit_format_pkg::POSIT_WIDTH-1:0] in1,
    input  wire logic [posit_format_pkg::POSIT_WIDTH-1:0] in2,
    input  wire logic                                     start,
    output posit_raw_pkg::raw_pair_t                      operands,
    output logic                                          operands_valid
);

    localparam int W = posit_format_pkg::POSIT_WIDTH;
    localparam int ES = posit_format_pkg::POSIT_ES;
    localparam int FW = posit_format_pkg::FRAC_WIDTH;
    localparam int KW = posit_format_pkg::SCALE_WIDTH - ES; // Width of regime value k

    // Length of the leading zero run, W-1 when the vector is all zeros
    function automatic logic [5:0] lead_zeros(input logic [W-2:0] x);
        logic [5:0] n;
        n = 6'(W - 1);
        for (int i = 0; i < W - 1; i++)
            if (x[i])
                n = 6'(W - 2 - i); // Highest set bit wins
        return n;
    endfunction

    function automatic posit_raw_pkg::raw_value_t decode_word(input logic [W-1:0] w);
        posit_raw_pkg::raw_value_t v;
        logic [W-1:0]  mag;
        logic [W-2:0]  body;
        logic [W-2:0]  rem;
        logic [5:0]    run;
        logic [KW-1:0] k;
        v = '0;
        if (w == '0)
            v.zero = 1'b1;
        else if (w == posit_format_pkg::NAR_PATTERN)
            v.inf = 1'b1;
        else
        begin
            mag = w[W-1] ? -w : w; // Negative posits are two's complement
            body = mag[W-2:0];
            // Regime is a run of copies of the first body bit
            run = lead_zeros(body[W-2] ? ~body : body);
            k = body[W-2] ? KW'(run - 6'd1) : KW'(-run);
            rem = body << (run + 6'd1); // Drop regime and its terminating bit
            v.sign = w[W-1];
            v.scale = {k, rem[W-2 -: ES]};
            v.fraction = rem[W-2-ES -: FW];
        end
        return v;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
            operands_valid <= 1'b0;
        else
            operands_valid <= start;
    end

    always_ff @(posedge clk)
    begin
        operands.a <= decode_word(in1);
        operands.b <= decode_word(in2);
    end

endmodule

`default_nettype wire

/* logic/posit_raw_add.sv */
// Four-stage raw adder, one operation per clock, no stall
// Bits lost in alignment are folded into a sticky bit and reported as align_inexact

`timescale 1ns/1ps
`default_nettype none

module posit_raw_add (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire posit_raw_pkg::raw_pair_t operands,
    input  wire logic                     operands_valid,
    output posit_raw_pkg::raw_sum_t       sum,
    output logic                          sum_valid,
    output logic                          align_inexact
);

    localparam int SW = posit_format_pkg::SCALE_WIDTH;
    localparam int GUARD = posit_format_pkg::SUM_FRAC_WIDTH - posit_format_pkg::FRAC_WIDTH;
    localparam int MANT_W = 1 + posit_format_pkg::SUM_FRAC_WIDTH; // Hidden bit plus fraction

    // Leading zeros of the raw sum, MANT_W+1 when the sum is zero
    function automatic logic [5:0] lead_zeros(input logic [MANT_W:0] x);
        logic [5:0] n;
        n = 6'(MANT_W + 1);
        for (int i = 0; i <= MANT_W; i++)
            if (x[i])
                n = 6'(MANT_W - i);
        return n;
    endfunction

    // Stage 1: order by magnitude, zero counts as smallest
    logic a_ge_b;
    posit_raw_pkg::raw_value_t r1_hi, r1_lo;
    logic r1_sub, r1_valid;

    assign a_ge_b = operands.b.zero | (~operands.a.zero &
        (($signed(operands.a.scale) > $signed(operands.b.scale)) |
         ((operands.a.scale == operands.b.scale) &
          (operands.a.fraction >= operands.b.fraction))));

    always_ff @(posedge clk)
    begin
        r1_hi <= a_ge_b ? operands.a : operands.b;
        r1_lo <= a_ge_b ? operands.b : operands.a;
        r1_sub <= operands.a.sign ^ operands.b.sign; // Unequal signs subtract
    end

    // Stage 2: align the smaller operand and add or subtract
    logic [SW:0]         scale_diff;
    logic [MANT_W-1:0]   hi_ext, lo_ext, lo_aligned;
    logic [2*MANT_W-1:0] lo_wide;
    logic                align_sticky;
    logic [MANT_W:0]     sum_comb;

    assign scale_diff = {r1_hi.scale[SW-1], r1_hi.scale} - {r1_lo.scale[SW-1], r1_lo.scale};
    assign hi_ext = {~r1_hi.zero, r1_hi.fraction, {GUARD{1'b0}}};
    assign lo_ext = {~r1_lo.zero, r1_lo.fraction, {GUARD{1'b0}}};
    assign lo_wide = {lo_ext, {MANT_W{1'b0}}} >> scale_diff; // Lower half catches lost bits
    // A shift of MANT_W or more moves the whole operand out of the upper half
    assign align_sticky = |lo_wide[MANT_W-1:0] |
                          (~r1_lo.zero & (scale_diff >= (SW+1)'(MANT_W)));
    assign lo_aligned = {lo_wide[2*MANT_W-1:MANT_W+1], lo_wide[MANT_W] | align_sticky};
    assign sum_comb = r1_sub ? {1'b0, hi_ext} - {1'b0, lo_aligned}
                             : {1'b0, hi_ext} + {1'b0, lo_aligned};

    logic [MANT_W:0] r2_sum_raw;
    logic [SW-1:0]   r2_scale;
    logic r2_sign, r2_inf, r2_zero, r2_sticky, r2_valid;

    always_ff @(posedge clk)
    begin
        r2_sum_raw <= sum_comb;
        r2_scale <= r1_hi.scale;
        r2_sign <= r1_hi.sign;
        r2_inf <= r1_hi.inf | r1_lo.inf;
        r2_zero <= r1_hi.zero & r1_lo.zero;
        r2_sticky <= align_sticky;
    end

    // Stage 3: leading one and scale adjust
    logic [5:0]    r2_lead;
    logic [SW+1:0] scale_wide;
    logic [SW-1:0] scale_adj;

    assign r2_lead = lead_zeros(r2_sum_raw);
    // Hidden bit sits one below the carry bit
    assign scale_wide = {{2{r2_scale[SW-1]}}, r2_scale} + (SW+2)'(1) - {{(SW-4){1'b0}}, r2_lead};
    // Deep cancellation below the scale range still encodes as minpos
    assign scale_adj = ($signed(scale_wide) < -(2 ** (SW - 1))) ? {1'b1, {(SW-1){1'b0}}}
                                                               : scale_wide[SW-1:0];

    logic [MANT_W:0] r3_sum_raw;
    logic [5:0]      r3_lead;
    logic [SW-1:0]   r3_scale;
    logic r3_sign, r3_inf, r3_zero, r3_sticky, r3_valid;

    always_ff @(posedge clk)
    begin
        r3_sum_raw <= r2_sum_raw;
        r3_lead <= r2_lead;
        r3_scale <= scale_adj;
        r3_sign <= r2_sign;
        r3_inf <= r2_inf;
        r3_zero <= r2_zero | (r2_sum_raw == '0); // Exact cancellation
        r3_sticky <= r2_sticky;
    end

    // Stage 4: normalize, leading one moves to the top bit
    logic [MANT_W:0] norm;

    assign norm = r3_sum_raw << r3_lead;

    always_ff @(posedge clk)
    begin
        sum.sign <= r3_sign & ~r3_inf & ~r3_zero;
        sum.scale <= r3_scale;
        sum.fraction <= {norm[MANT_W-1:2], norm[1] | norm[0]}; // Bit 0 keeps a carry-out loss
        sum.inf <= r3_inf; // Inf wins over everything
        sum.zero <= r3_zero & ~r3_inf;
        align_inexact <= r3_sticky & ~r3_inf & ~r3_zero;
    end

    // Strobe chain
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            r1_valid <= 1'b0;
            r2_valid <= 1'b0;
            r3_valid <= 1'b0;
            sum_valid <= 1'b0;
        end
        else
        begin
            r1_valid <= operands_valid;
            r2_valid <= r1_valid;
            r3_valid <= r2_valid;
            sum_valid <= r3_valid;
        end
    end

endmodule

`default_nettype wire

/* logic/posit_encode.sv */
// Packs a raw sum into a posit word, round to nearest even, one register stage
// Nonzero sums saturate at maxpos or minpos, never to zero or NaR

`timescale 1ns/1ps
`default_nettype none

module posit_encode (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire posit_raw_pkg::raw_sum_t                   sum,
    input  wire logic                                      sum_valid,
    input  wire logic                                      align_inexact,
    output logic [posit_format_pkg::POSIT_WIDTH-1:0]       result,
    output logic                                           done,
    output logic                                           truncated
);

    localparam int W = posit_format_pkg::POSIT_WIDTH;
    localparam int ES = posit_format_pkg::POSIT_ES;
    localparam int SW = posit_format_pkg::SCALE_WIDTH;
    localparam int MAX_SCALE = (W - 2) * (2 ** ES);                // Scale of maxpos
    localparam int ENC_W = 2 + ES + posit_format_pkg::SUM_FRAC_WIDTH + (W - 2); // Room for shift
    localparam logic [W-1:0] MAXPOS = {1'b0, {(W-1){1'b1}}};
    localparam logic [W-1:0] MINPOS = W'(1);

    logic [SW-ES-1:0]        k;       // Regime value
    logic [SW-ES-1:0]        run_sh;
    logic signed [ENC_W-1:0] packed_bits;
    logic [ENC_W-1:0]        shifted;
    logic [W-2:0]            body, body_rounded;
    logic                    guard, sticky, round_up;
    logic [W-1:0]            mag, next_result;
    logic                    next_truncated;

    assign k = sum.scale[SW-1:ES];
    assign run_sh = k[SW-ES-1] ? ~k : k; // k for k >= 0, -k-1 otherwise

    // Top bit fills the regime run on the arithmetic shift
    assign packed_bits = {~k[SW-ES-1], k[SW-ES-1], sum.scale[ES-1:0], sum.fraction,
                          {(W-2){1'b0}}};
    assign shifted = packed_bits >>> run_sh;

    assign body = shifted[ENC_W-1 -: W-1];
    assign guard = shifted[ENC_W-W];
    assign sticky = |shifted[ENC_W-W-1:0];
    assign round_up = guard & (sticky | body[0]); // Ties to even
    assign body_rounded = body + {{(W-2){1'b0}}, round_up};

    always_comb
    begin
        mag = {1'b0, body_rounded};
        next_truncated = align_inexact | guard | sticky;
        if ($signed(sum.scale) > MAX_SCALE)
        begin
            mag = MAXPOS;
            next_truncated = 1'b1;
        end
        else if ($signed(sum.scale) < -MAX_SCALE)
        begin
            mag = MINPOS;
            next_truncated = 1'b1;
        end

        next_result = sum.sign ? -mag : mag;
        if (sum.inf)
        begin
            next_result = posit_format_pkg::NAR_PATTERN;
            next_truncated = 1'b0;
        end
        else if (sum.zero)
        begin
            next_result = '0;
            next_truncated = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        result <= next_result;
        truncated <= next_truncated;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else
            done <= sum_valid;
    end

endmodule

`default_nettype wire

/* logic/posit_add_top.sv */
// 32-bit posit adder (es = 3), fixed latency of 6 clocks from start to done
// New operands may be applied on every clock; there is no back-pressure

`timescale 1ns/1ps
`default_nettype none

module posit_add_top (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    input  wire logic [posit_format_pkg::POSIT_WIDTH-1:0] in1,
    input  wire logic [posit_format_pkg::POSIT_WIDTH-1:0] in2,
    input  wire logic                                     start,
    output logic [posit_format_pkg::POSIT_WIDTH-1:0]      result,
    output logic                                          done,
    output logic                                          truncated
);

    posit_raw_pkg::raw_pair_t operands;
    posit_raw_pkg::raw_sum_t  sum;
    logic operands_valid, sum_valid, align_inexact;

    posit_decode decode (
        .clk(clk), .reset(reset), .in1(in1), .in2(in2), .start(start),
        .operands(operands), .operands_valid(operands_valid)
    );

    posit_raw_add raw_add (
        .clk(clk), .reset(reset), .operands(operands), .operands_valid(operands_valid),
        .sum(sum), .sum_valid(sum_valid), .align_inexact(align_inexact)
    );

    posit_encode encode (
        .clk(clk), .reset(reset), .sum(sum), .sum_valid(sum_valid),
        .align_inexact(align_inexact), .result(result), .done(done), .truncated(truncated)
    );

endmodule

`default_nettype wire

/* tb/posit_add_vectors.svh */
// Vector table for the posit adder testbench, 32-bit posits with es = 3
// Rows are applied back to back; a gap row leaves start low for one cycle

`ifndef POSIT_ADD_VECTORS_SVH
`define POSIT_ADD_VECTORS_SVH

// Columns: test name, in1, in2, expected sum, expected truncated
task automatic build_vector_table();
    // Exact sums
    add_vector("one_plus_one",         32'h4000_0000, 32'h4000_0000, 32'h4400_0000, 1'b0);
    add_vector("one_half_plus_quarter", 32'h4200_0000, 32'h3800_0000, 32'h4300_0000, 1'b0);
    add_vector("neg_three_plus_one",   32'hBA00_0000, 32'h4000_0000, 32'hBC00_0000, 1'b0);
    add_vector("one_plus_neg_three",   32'h4000_0000, 32'hBA00_0000, 32'hBC00_0000, 1'b0);
    add_vector("k1_plus_k1",           32'h6000_0000, 32'h6000_0000, 32'h6200_0000, 1'b0);
    add_vector("quarter_plus_quarter", 32'h3800_0000, 32'h3800_0000, 32'h3C00_0000, 1'b0);
    add_vector("one_plus_neg_half",    32'h4000_0000, 32'hC400_0000, 32'h3C00_0000, 1'b0);

    // Zero, cancellation and NaR
    add_vector("x_plus_zero",          32'h4600_0000, 32'h0000_0000, 32'h4600_0000, 1'b0);
    add_vector("zero_plus_x",          32'h0000_0000, 32'hBC00_0000, 32'hBC00_0000, 1'b0);
    add_vector("zero_plus_zero",       32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_vector("x_plus_neg_x",         32'h4600_0000, 32'hBA00_0000, 32'h0000_0000, 1'b0);
    add_vector("nar_plus_one",         32'h8000_0000, 32'h4000_0000, 32'h8000_0000, 1'b0);
    add_vector("one_plus_nar",         32'h4000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0);
    add_vector("nar_plus_zero",        32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 1'b0);
    leave_gap();

    // Half-ulp ties at scale 0 and at regime k = 1, then above half
    add_vector("tie_to_even_down",     32'h4000_0000, 32'h0680_0000, 32'h4000_0000, 1'b1);
    add_vector("tie_to_even_up",       32'h4000_0001, 32'h0680_0000, 32'h4000_0002, 1'b1);
    add_vector("above_half_rounds_up", 32'h4000_0000, 32'h06C0_0000, 32'h4000_0001, 1'b1);
    add_vector("k1_tie_to_even",       32'h6000_0000, 32'h0E00_0000, 32'h6000_0000, 1'b1);
    add_vector("one_plus_minpos",      32'h4000_0000, 32'h0000_0001, 32'h4000_0000, 1'b1);
    leave_gap();
    leave_gap();

    // Saturation at both ends
    add_vector("maxpos_plus_maxpos",   32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 1'b1);
    add_vector("neg_maxpos_sum",       32'h8000_0001, 32'h8000_0001, 32'h8000_0001, 1'b1);
    add_vector("maxpos_plus_one",      32'h7FFF_FFFF, 32'h4000_0000, 32'h7FFF_FFFF, 1'b1);
    add_vector("minpos_plus_minpos",   32'h0000_0001, 32'h0000_0001, 32'h0000_0001, 1'b1);
endtask

`endif

/* tb/posit_add_tb.sv */
// Table-driven testbench for the posit adder, one operation per clock
// Expects done exactly 6 clocks after the clock that drives start

`timescale 1ns/1ps
`default_nettype none

module posit_add_tb;

    localparam int W = posit_format_pkg::POSIT_WIDTH;
    localparam int LATENCY = 6;

    typedef struct packed {
        logic         start;
        logic [W-1:0] in1;
        logic [W-1:0] in2;
        logic [W-1:0] sum;
        logic         truncated;
    } vector_t;

    typedef struct packed {
        logic [W-1:0] sum;
        logic         truncated;
        logic [31:0]  due;       // Cycle count at the falling edge where done is due
    } expected_t;

    logic         clk, reset, start, done, truncated;
    logic [W-1:0] in1, in2, result;

    vector_t   table_q[$];
    string     name_q[$];
    expected_t exp_q[$];
    string     exp_name_q[$];
    expected_t head;
    string     head_name;
    int        cycle, timeout_limit, checks, errors;

    posit_add_top UUT (
        .clk(clk), .reset(reset), .in1(in1), .in2(in2), .start(start),
        .result(result), .done(done), .truncated(truncated)
    );

    task automatic add_vector(input string name, input logic [W-1:0] a, input logic [W-1:0] b,
                              input logic [W-1:0] sum, input logic trunc);
        vector_t v;
        v = '{start: 1'b1, in1: a, in2: b, sum: sum, truncated: trunc};
        table_q.push_back(v);
        name_q.push_back(name);
    endtask

    task automatic leave_gap();
        table_q.push_back('0);
        name_q.push_back("gap");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    `include "posit_add_vectors.svh"

    always #10 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit)
        begin
            $display("Timeout after %0d cycles with %0d results outstanding", cycle,
                     exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // Outputs are sampled on the falling edge, half a period after they change
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (done === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Done rose at cycle %0d with no operation outstanding", cycle);
                end
                else
                begin
                    head = exp_q.pop_front();
                    head_name = exp_name_q.pop_front();
                    check_value({head_name, " result"}, head.sum, result);
                    check_value({head_name, " truncated"}, head.truncated, truncated);
                    check_value({head_name, " done cycle"}, head.due, cycle);
                end
            end
            else if (done !== 1'b0)
            begin
                errors++;
                $display("Done is unknown at cycle %0d", cycle);
            end
            else if (exp_q.size() != 0 && exp_q[0].due == cycle)
            begin
                errors++;
                $display("Done did not rise for %s at cycle %0d", exp_name_q[0], cycle);
                head = exp_q.pop_front();
                head_name = exp_name_q.pop_front();
            end
        end
    end

    initial
    begin
        expected_t entry;
        int drain;
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        in1 = '0;
        in2 = '0;
        cycle = 0;
        checks = 0;
        errors = 0;
        build_vector_table();
        timeout_limit = table_q.size() + LATENCY + 20;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < table_q.size(); i++)
        begin
            @(posedge clk);
            start <= table_q[i].start;
            in1 <= table_q[i].in1;
            in2 <= table_q[i].in2;
            if (table_q[i].start)
            begin
                entry.sum = table_q[i].sum;
                entry.truncated = table_q[i].truncated;
                entry.due = cycle + 1 + LATENCY; // Count steps once before the first check
                exp_q.push_back(entry);
                exp_name_q.push_back(name_q[i]);
            end
        end
        @(posedge clk);
        start <= 1'b0;
        in1 <= '0;
        in2 <= '0;

        drain = 0;
        while (exp_q.size() != 0 && drain < LATENCY + 4)
        begin
            @(posedge clk);
            drain++;
        end
        repeat (2) @(posedge clk); // A stray done would show here

        if (exp_q.size() != 0)
        begin
            errors += exp_q.size();
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+tb
logic/posit_format_pkg.sv
logic/posit_raw_pkg.sv
logic/posit_decode.sv
logic/posit_raw_add.sv
logic/posit_encode.sv
logic/posit_add_top.sv
tb/posit_add_tb.sv
